//--- hdl/emu_pkg.sv
package emu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;
    typedef logic [31:0] cpu_addr_t;
    typedef logic [12:0] host_addr_t;
    typedef logic [9:0]  word_index_t;
    typedef logic [63:0] cycle_t;

    typedef enum logic {
        HOST_IDLE,
        HOST_RESPOND
    } host_state_t;

    // Register byte offsets, host address bit 12 clear
    localparam logic [11:0] REG_CSR      = 12'h000;
    localparam logic [11:0] REG_CYCLE_LO = 12'h008;
    localparam logic [11:0] REG_CYCLE_HI = 12'h00c;

    // Processor store here sets halt
    localparam cpu_addr_t HALT_TRIGGER_ADDR = 32'h0000_000c;

    // Words per byte lane
    localparam int MEM_DEPTH = 1024;

endpackage

//--- hdl/mem_lane.sv
`timescale 1ns/100ps

module mem_lane import emu_pkg::*; #(
    parameter int MEM_DEPTH = emu_pkg::MEM_DEPTH
) (
    input  logic        clk,

    input  logic        cpu_we,
    input  word_index_t cpu_index,
    input  logic [7:0]  cpu_wdata,

    input  logic        host_we,
    input  word_index_t host_index,
    input  logic [7:0]  host_wdata,

    input  word_index_t fetch_index,
    output logic [7:0]  fetch_rdata,
    input  word_index_t data_index,
    output logic [7:0]  data_rdata,
    input  word_index_t host_index_rd,
    output logic [7:0]  host_rdata
);

    logic [7:0] mem [MEM_DEPTH];

    // Host write is last, so it wins when both hit the same entry
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_index] <= cpu_wdata;
        end
        if (host_we) begin
            mem[host_index] <= host_wdata;
        end
    end

    assign fetch_rdata = mem[fetch_index];
    assign data_rdata  = mem[data_index];
    assign host_rdata  = mem[host_index_rd];

endmodule

//--- hdl/emu_control.sv
`timescale 1ns/100ps

module emu_control import emu_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        reg_we,
    input  logic [11:0] reg_offset,
    input  word_t       reg_wdata,

    input  cpu_addr_t   mem_addr,
    input  logic        mem_we,

    output logic        halt,
    output word_t       csr_value,
    output word_t       cycle_lo,
    output word_t       cycle_hi
);

    cycle_t cycle;
    logic   trigger;
    logic   csr_write;
    logic   lo_write;
    logic   hi_write;

    assign trigger   = mem_we && (mem_addr == HALT_TRIGGER_ADDR);
    assign csr_write = reg_we && (reg_offset == REG_CSR);
    assign lo_write  = reg_we && (reg_offset == REG_CYCLE_LO);
    assign hi_write  = reg_we && (reg_offset == REG_CYCLE_HI);

    // Trigger store beats a CSR write in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            halt <= 1'b0;
        end else if (trigger) begin
            halt <= 1'b1;
        end else if (csr_write) begin
            halt <= reg_wdata[0];
        end
    end

    // Count while running, loadable only while halted
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!halt) begin
            cycle <= cycle + 64'd1;
        end else begin
            if (lo_write) begin
                cycle[31:0] <= reg_wdata;
            end
            if (hi_write) begin
                cycle[63:32] <= reg_wdata;
            end
        end
    end

    assign csr_value = {31'd0, halt};
    assign cycle_lo  = cycle[31:0];
    assign cycle_hi  = cycle[63:32];

    a_cycle_frozen: assert property (
        @(posedge clk) disable iff (rst)
        (halt && !lo_write && !hi_write) |=> $stable(cycle)
    );

endmodule

//--- hdl/emu_host_bus.sv
`timescale 1ns/100ps

module emu_host_bus import emu_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  host_addr_t  wb_adr,
    input  word_t       wb_dat_w,
    input  strobe_t     wb_sel,
    output word_t       wb_dat_r,
    output logic        wb_ack,
    output logic        wb_err,

    output logic [3:0]  host_mem_we,
    output word_index_t host_mem_index,
    output word_t       host_mem_wdata,
    input  word_t       host_mem_rdata,

    output logic        reg_we,
    output logic [11:0] reg_offset,
    output word_t       reg_wdata,
    input  word_t       csr_value,
    input  word_t       cycle_lo,
    input  word_t       cycle_hi
);

    host_state_t state;
    logic        req;
    logic        sel_mem;
    logic        sel_full;
    logic        sel_err;
    word_t       reg_rdata;

    // Only taken in idle, the held stb is masked while responding
    assign req      = (state == HOST_IDLE) && wb_cyc && wb_stb;
    assign sel_mem  = wb_adr[12];
    assign sel_full = (wb_sel == 4'hf);

    // Partial register write
    assign sel_err  = wb_we && !sel_mem && !sel_full;

    assign host_mem_index = wb_adr[11:2];
    assign host_mem_wdata = wb_dat_w;
    assign host_mem_we    = {4{req && wb_we && sel_mem}} & wb_sel;

    assign reg_offset = wb_adr[11:0];
    assign reg_wdata  = wb_dat_w;
    assign reg_we     = req && wb_we && !sel_mem && sel_full;

    always_comb begin
        case (reg_offset)
            REG_CSR:      reg_rdata = csr_value;
            REG_CYCLE_LO: reg_rdata = cycle_lo;
            REG_CYCLE_HI: reg_rdata = cycle_hi;
            default:      reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= HOST_IDLE;
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else begin
            case (state)
                HOST_IDLE: begin
                    wb_ack <= req && !sel_err;
                    wb_err <= req && sel_err;
                    if (req) begin
                        state <= HOST_RESPOND;
                    end
                end
                HOST_RESPOND: begin
                    wb_ack <= 1'b0;
                    wb_err <= 1'b0;
                    state  <= HOST_IDLE;
                end
                default: begin
                    state <= HOST_IDLE;
                end
            endcase
        end
    end

    // Read data lands with ack
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= sel_mem ? host_mem_rdata : reg_rdata;
        end
    end

    a_ack_err_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(wb_ack && wb_err)
    );

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack
    );

endmodule

//--- hdl/emu_top.sv
`timescale 1ns/100ps

module emu_top import emu_pkg::*; #(
    parameter int MEM_DEPTH = emu_pkg::MEM_DEPTH
) (
    input  logic       clk,
    input  logic       rst,

    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  host_addr_t wb_adr,
    input  word_t      wb_dat_w,
    input  strobe_t    wb_sel,
    output word_t      wb_dat_r,
    output logic       wb_ack,
    output logic       wb_err,

    input  cpu_addr_t  pc,
    output word_t      instruction,

    input  cpu_addr_t  mem_addr,
    input  logic       mem_we,
    input  word_t      mem_wdata,
    input  strobe_t    mem_wstrb,
    output word_t      mem_rdata,

    output logic       halt
);

    logic [3:0]  host_mem_we;
    word_index_t host_mem_index;
    word_t       host_mem_wdata;
    word_t       host_mem_rdata;

    logic        reg_we;
    logic [11:0] reg_offset;
    word_t       reg_wdata;
    word_t       csr_value;
    word_t       cycle_lo;
    word_t       cycle_hi;

    word_index_t fetch_index;
    word_index_t data_index;

    assign fetch_index = pc[11:2];
    assign data_index  = mem_addr[11:2];

    emu_host_bus i_emu_host_bus (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_sel         (wb_sel),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .wb_err         (wb_err),
        .host_mem_we    (host_mem_we),
        .host_mem_index (host_mem_index),
        .host_mem_wdata (host_mem_wdata),
        .host_mem_rdata (host_mem_rdata),
        .reg_we         (reg_we),
        .reg_offset     (reg_offset),
        .reg_wdata      (reg_wdata),
        .csr_value      (csr_value),
        .cycle_lo       (cycle_lo),
        .cycle_hi       (cycle_hi)
    );

    emu_control i_emu_control (
        .clk        (clk),
        .rst        (rst),
        .reg_we     (reg_we),
        .reg_offset (reg_offset),
        .reg_wdata  (reg_wdata),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .halt       (halt),
        .csr_value  (csr_value),
        .cycle_lo   (cycle_lo),
        .cycle_hi   (cycle_hi)
    );

    // One lane per byte of the word
    for (genvar i = 0; i < 4; i++) begin : g_lane
        mem_lane #(
            .MEM_DEPTH (MEM_DEPTH)
        ) i_mem_lane (
            .clk           (clk),
            .cpu_we        (mem_we && mem_wstrb[i]),
            .cpu_index     (data_index),
            .cpu_wdata     (mem_wdata[8*i +: 8]),
            .host_we       (host_mem_we[i]),
            .host_index    (host_mem_index),
            .host_wdata    (host_mem_wdata[8*i +: 8]),
            .fetch_index   (fetch_index),
            .fetch_rdata   (instruction[8*i +: 8]),
            .data_index    (data_index),
            .data_rdata    (mem_rdata[8*i +: 8]),
            .host_index_rd (host_mem_index),
            .host_rdata    (host_mem_rdata[8*i +: 8])
        );
    end

endmodule

//--- tb/emu_checks.svh
`ifndef EMU_CHECKS_SVH
`define EMU_CHECKS_SVH

// One Wishbone classic access, held until ack or err
task automatic host_access(input logic we, input host_addr_t adr, input word_t wdata,
                           input strobe_t sel, output word_t rdata, output logic got_err);
    int   waited;
    logic got_resp;
    waited   = 0;
    got_resp = 1'b0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    wb_sel   = sel;
    while (!got_resp && waited < ACK_TIMEOUT) begin
        @(posedge clk);
        #DRIVE_DELAY;
        waited++;
        got_resp = wb_ack || wb_err;
    end
    if (!got_resp) begin
        $display("No ack or err came back within %0d cycles for host address %h",
                 ACK_TIMEOUT, adr);
        timeouts++;
    end
    rdata   = wb_dat_r;
    got_err = wb_err;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
endtask

task automatic check_word(input string name, input word_t actual, input word_t expected);
    check_count++;
    if (actual !== expected) begin
        $display("Fail %s: got %h, expected %h", name, actual, expected);
        value_errors++;
    end
endtask

task automatic check_cycle(input string name, input cycle_t actual, input cycle_t expected);
    check_count++;
    if (actual !== expected) begin
        $display("Fail %s: got %h, expected %h", name, actual, expected);
        value_errors++;
    end
endtask

// Err when one is expected, ack otherwise
task automatic check_resp(input string name, input logic got_err, input logic expect_err);
    check_count++;
    if (got_err !== expect_err) begin
        $display("Fail %s: got %h, expected %h", name, got_err, expect_err);
        resp_errors++;
    end
endtask

// Low half first, then high half
task automatic read_cycle(output cycle_t value);
    word_t lo;
    word_t hi;
    logic  err_lo;
    logic  err_hi;
    host_access(1'b0, {1'b0, REG_CYCLE_LO}, '0, 4'hf, lo, err_lo);
    check_resp("wb_err", err_lo, 1'b0);
    host_access(1'b0, {1'b0, REG_CYCLE_HI}, '0, 4'hf, hi, err_hi);
    check_resp("wb_err", err_hi, 1'b0);
    value = {hi, lo};
endtask

`endif

//--- tb/emu_tb.sv
`timescale 1ns/100ps

module emu_tb import emu_pkg::*; ();

    localparam int CLK_HALF    = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int ACK_TIMEOUT = 20;
    localparam int TRACE_LINES = 64;
    localparam int TRACE_WORDS = 5 * TRACE_LINES;

    // Trace op codes
    localparam logic [3:0] OP_HOST_WRITE  = 4'h1;
    localparam logic [3:0] OP_HOST_READ   = 4'h2;
    localparam logic [3:0] OP_CPU_STORE   = 4'h3;
    localparam logic [3:0] OP_CPU_LOAD    = 4'h4;
    localparam logic [3:0] OP_CPU_FETCH   = 4'h5;
    localparam logic [3:0] OP_CYCLE_SNAP  = 4'h6;
    localparam logic [3:0] OP_CYCLE_SAME  = 4'h7;
    localparam logic [3:0] OP_CYCLE_EXACT = 4'h9;
    localparam logic [3:0] OP_CYCLE_ABOVE = 4'ha;
    localparam logic [3:0] OP_HALT        = 4'hb;
    localparam logic [3:0] OP_END         = 4'hf;

    logic       clk;
    logic       rst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    host_addr_t wb_adr;
    word_t      wb_dat_w;
    strobe_t    wb_sel;
    word_t      wb_dat_r;
    logic       wb_ack;
    logic       wb_err;
    cpu_addr_t  pc;
    word_t      instruction;
    cpu_addr_t  mem_addr;
    logic       mem_we;
    word_t      mem_wdata;
    strobe_t    mem_wstrb;
    word_t      mem_rdata;
    logic       halt;

    logic [63:0] trace_mem [TRACE_WORDS];

    int check_count;
    int value_errors;
    int resp_errors;
    int timeouts;
    int trace_errors;

    `include "emu_checks.svh"

    emu_top #(
        .MEM_DEPTH (1024)
    ) i_emu_top (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_sel      (wb_sel),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .wb_err      (wb_err),
        .pc          (pc),
        .instruction (instruction),
        .mem_addr    (mem_addr),
        .mem_we      (mem_we),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_rdata   (mem_rdata),
        .halt        (halt)
    );

    always #CLK_HALF clk = ~clk;

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    // Store lands at the next edge
    task automatic cpu_store(input cpu_addr_t addr, input word_t data, input strobe_t strb);
        mem_addr  = addr;
        mem_wdata = data;
        mem_wstrb = strb;
        mem_we    = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        mem_we    = 1'b0;
        mem_wstrb = '0;
    endtask

    // Combinational reads, sampled mid cycle
    task automatic cpu_load(input cpu_addr_t addr, input word_t expected);
        mem_addr = addr;
        @(negedge clk);
        check_word("mem_rdata", mem_rdata, expected);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic cpu_fetch(input cpu_addr_t addr, input word_t expected);
        pc = addr;
        @(negedge clk);
        check_word("instruction", instruction, expected);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin
        int          seed_value;
        int          line;
        logic        done;
        logic [3:0]  op;
        logic [63:0] addr;
        logic [63:0] data;
        logic [63:0] strb;
        logic [63:0] exp_val;
        word_t       rdata;
        logic        got_err;
        cycle_t      cycle_value;
        cycle_t      snapshot;

        seed_value   = $urandom(32'h4ded_cfe2);
        check_count  = 0;
        value_errors = 0;
        resp_errors  = 0;
        timeouts     = 0;
        trace_errors = 0;
        snapshot     = '0;
        clk          = 1'b0;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        wb_sel       = '0;
        pc           = '0;
        mem_addr     = '0;
        mem_we       = 1'b0;
        mem_wdata    = '0;
        mem_wstrb    = '0;

        $readmemh("tb/emu_trace.txt", trace_mem);

        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        line = 0;
        done = 1'b0;
        while (!done && line < TRACE_LINES) begin
            op      = trace_mem[5 * line][3:0];
            addr    = trace_mem[5 * line + 1];
            data    = trace_mem[5 * line + 2];
            strb    = trace_mem[5 * line + 3];
            exp_val = trace_mem[5 * line + 4];
            case (op)
                OP_HOST_WRITE: begin
                    host_access(1'b1, addr[12:0], data[31:0], strb[3:0], rdata, got_err);
                    check_resp("wb_err", got_err, exp_val[0]);
                end
                OP_HOST_READ: begin
                    host_access(1'b0, addr[12:0], '0, strb[3:0], rdata, got_err);
                    check_resp("wb_err", got_err, 1'b0);
                    check_word("wb_dat_r", rdata, exp_val[31:0]);
                end
                OP_CPU_STORE:   cpu_store(addr[31:0], data[31:0], strb[3:0]);
                OP_CPU_LOAD:    cpu_load(addr[31:0], exp_val[31:0]);
                OP_CPU_FETCH:   cpu_fetch(addr[31:0], exp_val[31:0]);
                OP_CYCLE_SNAP:  read_cycle(snapshot);
                OP_CYCLE_SAME: begin
                    read_cycle(cycle_value);
                    check_cycle("cycle", cycle_value, snapshot);
                end
                OP_CYCLE_EXACT: begin
                    read_cycle(cycle_value);
                    check_cycle("cycle", cycle_value, exp_val);
                end
                OP_CYCLE_ABOVE: begin
                    read_cycle(cycle_value);
                    check_count++;
                    if (cycle_value <= exp_val) begin
                        $display("Fail cycle: got %h, expected above %h", cycle_value, exp_val);
                        value_errors++;
                    end
                end
                OP_HALT:        check_word("halt", {31'd0, halt}, exp_val[31:0]);
                OP_END:         done = 1'b1;
                default: begin
                    $display("Trace line %0d holds an unknown operation code %h", line, op);
                    trace_errors++;
                    done = 1'b1;
                end
            endcase
            idle_cycles($urandom_range(3, 0));
            line++;
        end

        if (!done) begin
            $display("Trace ran out without an end operation");
            trace_errors++;
        end

        $display("Checks: %0d, value errors: %0d, response errors: %0d, timeouts: %0d, %s%0d",
                 check_count, value_errors, resp_errors, timeouts, "trace errors: ",
                 trace_errors);
        if (value_errors + resp_errors + timeouts + trace_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+tb
hdl/emu_pkg.sv
hdl/mem_lane.sv
hdl/emu_control.sv
hdl/emu_host_bus.sv
hdl/emu_top.sv
tb/emu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log
verilator --binary --timing --assert -j 0 --top-module emu_tb -f filelist.f \
    -o emu_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/emu_sim > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited with an error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0

//--- tb/emu_trace.txt
// Columns: op addr data strobes expected, all hex
// Ops: 1 host write, 2 host read, 3 cpu store, 4 cpu load, 5 cpu fetch, 6..b cycle/halt, f end
// Host write and merged read, seen on both processor ports
1 1010 11223344 f 0
1 1010 aabbccdd 5 0
2 1010 0 f 11bb33dd
4 10 0 0 11bb33dd
5 10 0 0 11bb33dd
1 1ffc deadbeef f 0
2 1ffc 0 3 deadbeef
4 80000ffc 0 0 deadbeef
5 ffc 0 0 deadbeef
// Partial processor stores
1 1020 00000000 f 0
3 20 cafef00d 6 0
2 1020 0 f 00fef000
4 20 0 0 00fef000
3 20 12345678 9 0
2 1020 0 f 12fef078
// Register strobe error, unmapped offsets, halt by CSR write
1 0000 00000001 3 1
2 0000 0 f 00000000
b 0 0 0 0
1 0008 12345678 1 1
2 0004 0 f 00000000
1 0004 ffffffff f 0
1 0000 00000001 f 0
2 0000 0 f 00000001
b 0 0 0 1
// Counter frozen while halted, loadable halves
6 0 0 0 0
7 0 0 0 0
1 0008 89abcdef f 0
1 000c 01234567 f 0
9 0 0 0 0123456789abcdef
1 0008 ffffffff 3 1
9 0 0 0 0123456789abcdef
2 0008 0 f 89abcdef
2 000c 0 f 01234567
// Counter resumes, then trigger store sets halt
1 0000 00000000 f 0
b 0 0 0 0
a 0 0 0 0123456789abcdef
3 10 55667788 f 0
b 0 0 0 0
3 c 0000abcd f 0
b 0 0 0 1
2 0000 0 f 00000001
4 c 0 0 0000abcd
6 0 0 0 0
7 0 0 0 0
1 0008 00001000 f 0
1 000c 00000005 f 0
9 0 0 0 0000000500001000
1 0000 00000000 f 0
b 0 0 0 0
a 0 0 0 0000000500001000
f 0 0 0 0
